/* alu_pkg.sv */
`default_nettype none

package alu_pkg;

	// ==============================
	// Data words
	// ==============================
	localparam int xlen = 32;

	typedef logic [xlen-1:0] value_t;

	// Returned for any function the unit does not implement
	localparam value_t dead_value = {(xlen/16){16'hdead}};

	// ==============================
	// Opcodes and R2 functions
	// ==============================
	typedef enum logic [6:0] {
		op_r2    = 7'd2,
		op_addi  = 7'd4,
		op_subfi = 7'd5,
		op_cmpi  = 7'd6,
		op_cmpui = 7'd7,
		op_muli  = 7'd8,
		op_mului = 7'd9,
		op_divi  = 7'd10,
		op_divui = 7'd11,
		op_andi  = 7'd12,
		op_ori   = 7'd13,
		op_eori  = 7'd14,
		op_shift = 7'd16,
		op_chk   = 7'd20,
		op_mov   = 7'd24,
		op_bsr   = 7'd32,
		op_nop   = 7'd127
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add    = 6'd4,
		fn_sub    = 6'd5,
		fn_and    = 6'd8,
		fn_or     = 6'd9,
		fn_eor    = 6'd10,
		fn_nand   = 6'd12,
		fn_nor    = 6'd13,
		fn_enor   = 6'd14,
		fn_cmp    = 6'd16,
		fn_cmpu   = 6'd17,
		fn_mul    = 6'd20,
		fn_mulu   = 6'd21,
		fn_div    = 6'd24,
		fn_divu   = 6'd25,
		fn_mod    = 6'd26,
		fn_modu   = 6'd27,
		fn_seq    = 6'd32,
		fn_sne    = 6'd33,
		fn_slt    = 6'd34,
		fn_sltu   = 6'd36,
		fn_zseq   = 6'd40,
		fn_zslt   = 6'd42,
		fn_cmovz  = 6'd48,
		fn_cmovnz = 6'd49,
		fn_minmax = 6'd56
	} func_t;

	// Shift types carried in the imm view; the three asr forms differ in rounding
	localparam logic [2:0] sh_asl    = 3'd0;
	localparam logic [2:0] sh_lsr    = 3'd1;
	localparam logic [2:0] sh_asr    = 3'd2;
	localparam logic [2:0] sh_asr_rz = 3'd3;
	localparam logic [2:0] sh_asr_rh = 3'd4;

	// ==============================
	// Fault causes
	// ==============================
	typedef logic [7:0] cause_t;

	localparam cause_t flt_none  = 8'h00;
	localparam cause_t flt_dbz   = 8'h08;
	localparam cause_t flt_unimp = 8'h0b;

	// ==============================
	// Instruction word
	// ==============================
	typedef struct packed {
		opcode_t     opcode;
		func_t       func;
		logic [3:0]  sub;
		logic [3:0]  cond;
		cause_t      cause;
		logic [2:0]  rsvd;
	} r2_instr_t;

	// Shift amount lives in the low six immediate bits
	typedef struct packed {
		opcode_t     opcode;
		logic [2:0]  sht;
		logic        amt_src;
		logic [20:0] imm;
	} imm_instr_t;

	typedef union packed {
		r2_instr_t  r2;
		imm_instr_t imm;
	} instr_t;

	// ==============================
	// Check configuration
	// ==============================
	typedef struct packed {
		value_t     canary;
		logic [7:0] cpl;
	} cfg_t;

	typedef enum logic {
		cfg_canary = 1'b0,
		cfg_cpl    = 1'b1
	} cfg_sel_t;

endpackage

`default_nettype wire

/* alu_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_cfg
	import alu_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     cfg_we,
	input  wire cfg_sel_t cfg_sel,
	input  wire value_t   cfg_wdata,
	output cfg_t          cfg
);

	// Checks see a written value from the cycle after the strobe
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cfg <= '0;
		end
		else if (cfg_we)
		begin
			case (cfg_sel)
			cfg_canary:
				cfg.canary <= cfg_wdata;
			cfg_cpl:
				cfg.cpl <= cfg_wdata[7:0];
			endcase
		end
	end

endmodule

`default_nettype wire

/* alu_cmp.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_cmp
	import alu_pkg::*;
(
	input  wire instr_t ir,
	input  wire value_t a,
	input  wire value_t b,
	input  wire value_t imm,
	output value_t      cmpo
);

	logic   use_imm;
	logic   sgn;
	value_t y;
	logic   eq;
	logic   lt;

	always_comb
	begin
		use_imm = (ir.r2.opcode == op_cmpi) || (ir.r2.opcode == op_cmpui);
		sgn = (ir.r2.opcode == op_cmpi) ||
			(ir.r2.opcode == op_r2 && ir.r2.func == fn_cmp);
		y = use_imm ? imm : b;

		eq = (a == y);
		lt = sgn ? ($signed(a) < $signed(y)) : (a < y);

		// Flag word, low bits only: eq, lt, le, gt, ge
		cmpo = '0;
		cmpo[0] = eq;
		cmpo[1] = lt;
		cmpo[2] = lt | eq;
		cmpo[3] = !(lt | eq);
		cmpo[4] = !lt;
	end

endmodule

`default_nettype wire

/* alu_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_shift
	import alu_pkg::*;
(
	input  wire instr_t ir,
	input  wire value_t a,
	input  wire value_t b,
	input  wire value_t c,
	output value_t      res
);

	logic [5:0]        amt;
	logic [2*xlen-1:0] shl;
	logic [2*xlen-1:0] shr;
	logic [3*xlen-1:0] asr;
	value_t            asr_q;
	logic              asr_half;
	logic              asr_frac;

	always_comb
	begin
		amt = ir.imm.amt_src ? ir.imm.imm[5:0] : c[5:0];

		// Funnel shifts; b supplies the bits shifted in beside a
		shl = {a, b} << amt;
		shr = {b, a} >> amt;

		// Two words of fraction below a keep every bit shifted out
		asr = $signed({a, {(2*xlen){1'b0}}}) >>> amt;
		asr_q = asr[3*xlen-1:2*xlen];
		asr_half = asr[2*xlen-1];
		asr_frac = |asr[2*xlen-1:0];

		case (ir.imm.sht)
		sh_asl:
			res = shl[2*xlen-1:xlen];
		sh_lsr:
			res = shr[xlen-1:0];
		sh_asr:
			res = asr_q;
		sh_asr_rz:
			res = (asr_q[xlen-1] && asr_frac) ? asr_q + 1'b1 : asr_q;
		sh_asr_rh:
			res = asr_q + value_t'(asr_half);
		default:
			res = dead_value;
		endcase
	end

endmodule

`default_nettype wire

/* alu_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_mul
	import alu_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          ld,
	input  wire value_t        a,
	input  wire value_t        b,
	output logic [2*xlen-1:0]  prod_s,
	output logic [2*xlen-1:0]  prod_u,
	output logic               mul_done
);

	logic [3:0]        mul_cnt;
	logic [2*xlen-1:0] ps2;
	logic [2*xlen-1:0] ps1;
	logic [2*xlen-1:0] pu2;
	logic [2*xlen-1:0] pu1;

	// ==============================
	// Product pipeline
	// ==============================
	always_ff @(posedge clk)
	begin
		ps2 <= $signed(a) * $signed(b);
		ps1 <= ps2;
		prod_s <= ps1;
		pu2 <= a * b;
		pu1 <= pu2;
		prod_u <= pu1;
	end

	// A one is seeded by ld and fills the counter; done follows the top bit
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mul_cnt <= '0;
			mul_done <= 1'b0;
		end
		else if (ld)
		begin
			mul_cnt <= 4'b0001;
			mul_done <= 1'b0;
		end
		else
		begin
			mul_cnt <= {mul_cnt[2:0], mul_cnt[0]};
			mul_done <= mul_cnt[3];
		end
	end

endmodule

`default_nettype wire

/* alu_div.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_div
	import alu_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   ld,
	input  wire logic   sgn,
	input  wire value_t a,
	input  wire value_t b,
	output value_t      quo,
	output value_t      rem,
	output logic        dbz,
	output logic        done
);

	logic [5:0]      cnt;
	value_t          q;
	value_t          r;
	value_t          d;
	value_t          dvd;
	logic            neg_q;
	logic            neg_r;
	logic [xlen:0]   trial;
	logic [xlen+1:0] diff;

	// One restoring step: bring in the next dividend bit and try the divisor
	always_comb
	begin
		trial = {r, q[xlen-1]};
		diff = {1'b0, trial} - {2'b00, d};
	end

	// ==============================
	// Control
	// ==============================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt <= '0;
			done <= 1'b0;
			dbz <= 1'b0;
		end
		else if (ld)
		begin
			cnt <= 6'(xlen + 1);
			done <= 1'b0;
			dbz <= 1'b0;
		end
		else if (cnt == 6'd1)
		begin
			cnt <= '0;
			done <= 1'b1;
			dbz <= (d == '0);
		end
		else if (cnt != 6'd0)
		begin
			cnt <= cnt - 1'b1;
		end
	end

	// ==============================
	// Datapath
	// ==============================
	always_ff @(posedge clk)
	begin
		if (ld)
		begin
			dvd <= a;
			q <= (sgn && a[xlen-1]) ? -a : a;
			d <= (sgn && b[xlen-1]) ? -b : b;
			r <= '0;
			neg_q <= sgn && (a[xlen-1] ^ b[xlen-1]);
			neg_r <= sgn && a[xlen-1];
		end
		else if (cnt == 6'd1)
		begin
			// Last cycle puts the signs back, or reports a zero divisor
			if (d == '0)
			begin
				quo <= '1;
				rem <= dvd;
			end
			else
			begin
				quo <= neg_q ? -q : q;
				rem <= neg_r ? -r : r;
			end
		end
		else if (cnt != 6'd0)
		begin
			if (!diff[xlen+1])
			begin
				r <= diff[xlen-1:0];
				q <= {q[xlen-2:0], 1'b1};
			end
			else
			begin
				r <= trial[xlen-1:0];
				q <= {q[xlen-2:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

/* alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_core
	import alu_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   ld,
	input  wire logic   cptgt,
	input  wire logic   z,
	input  wire instr_t ir,
	input  wire value_t a,
	input  wire value_t b,
	input  wire value_t c,
	input  wire value_t t,
	input  wire value_t imm,
	input  wire value_t pc,
	input  wire cfg_t   cfg,
	output value_t      o,
	output logic        mul_done,
	output logic        div_done,
	output logic        div_dbz,
	output cause_t      exc
);

	value_t            bi;
	value_t            cmpo;
	value_t            sh_res;
	logic [2*xlen-1:0] prod_s;
	logic [2*xlen-1:0] prod_u;
	value_t            quo;
	value_t            rem;
	logic              div_sgn;
	value_t            sum_ab;
	value_t            res;
	logic              lo_ok;
	logic              hi_ok;
	logic              in_rng;
	logic              chk_fail;
	logic              chk_unimp;

	// Second operand of a result combined with c; codes 0 to 5
	function automatic value_t with_c(value_t x, value_t y, logic [3:0] sub);
		case (sub)
		4'd0: return x & y;
		4'd1: return x & ~y;
		4'd2: return x | y;
		4'd3: return x | ~y;
		4'd4: return x ^ y;
		4'd5: return x ^ ~y;
		default: return dead_value;
		endcase
	endfunction

	function automatic logic less(value_t x, value_t y, logic sgn);
		return sgn ? ($signed(x) < $signed(y)) : (x < y);
	endfunction

	// Sub bit 2 picks unsigned; low bits pick min, max or mid
	function automatic value_t min_max_mid(value_t x, value_t y, value_t w, logic [3:0] sub);
		logic   sgn;
		value_t lo;
		value_t hi;
		sgn = !sub[2];
		lo = less(x, y, sgn) ? x : y;
		hi = less(x, y, sgn) ? y : x;
		if (sub[3] || sub[1:0] == 2'd3)
			return dead_value;
		case (sub[1:0])
		2'd0: return less(lo, w, sgn) ? lo : w;
		2'd1: return less(hi, w, sgn) ? w : hi;
		default: return less(w, lo, sgn) ? lo : (less(hi, w, sgn) ? hi : w);
		endcase
	endfunction

	// ==============================
	// Functional units
	// ==============================
	always_comb
	begin
		bi = (ir.r2.opcode inside {op_muli, op_mului, op_divi, op_divui}) ? imm : b;
		div_sgn = (ir.r2.opcode == op_divi) ||
			(ir.r2.opcode == op_r2 && (ir.r2.func == fn_div || ir.r2.func == fn_mod));
	end

	alu_cmp u_cmp (.ir(ir), .a(a), .b(b), .imm(imm), .cmpo(cmpo));

	alu_shift u_shift (.ir(ir), .a(a), .b(b), .c(c), .res(sh_res));

	alu_mul u_mul (
		.clk(clk), .rst(rst), .ld(ld), .a(a), .b(bi),
		.prod_s(prod_s), .prod_u(prod_u), .mul_done(mul_done)
	);

	alu_div u_div (
		.clk(clk), .rst(rst), .ld(ld), .sgn(div_sgn), .a(a), .b(bi),
		.quo(quo), .rem(rem), .dbz(div_dbz), .done(div_done)
	);

	// ==============================
	// Result select
	// ==============================
	always_comb
	begin
		sum_ab = a + b;
		res = dead_value;
		case (ir.r2.opcode)
		op_r2:
			case (ir.r2.func)
			fn_add:
				if (ir.r2.sub == 4'd8)
					res = sum_ab + c;
				else if (ir.r2.sub == 4'd9)
					res = sum_ab - c;
				else
					res = with_c(sum_ab, c, ir.r2.sub);
			fn_sub:    res = a - b - c;
			fn_and:    res = with_c(a & b, c, ir.r2.sub);
			fn_or:     res = with_c(a | b, c, ir.r2.sub);
			fn_eor:    res = with_c(a ^ b, c, ir.r2.sub);
			fn_nand:   res = with_c(~(a & b), c, ir.r2.sub);
			fn_nor:    res = with_c(~(a | b), c, ir.r2.sub);
			fn_enor:   res = with_c(~(a ^ b), c, ir.r2.sub);
			fn_cmp, fn_cmpu:
				res = (ir.r2.sub < 4'd6) ? with_c(cmpo, c, ir.r2.sub) : cmpo;
			fn_mul:    res = prod_s[xlen-1:0];
			fn_mulu:   res = prod_u[xlen-1:0];
			fn_div, fn_divu:
				res = quo;
			fn_mod, fn_modu:
				res = rem;
			fn_seq:    res = (a == b) ? c : t;
			fn_sne:    res = (a != b) ? c : t;
			fn_slt:    res = less(a, b, 1'b1) ? c : t;
			fn_sltu:   res = less(a, b, 1'b0) ? c : t;
			fn_zseq:   res = (a == b) ? c : '0;
			fn_zslt:   res = less(a, b, 1'b1) ? c : '0;
			fn_cmovz:  res = (a == '0) ? b : c;
			fn_cmovnz: res = (a != '0) ? b : c;
			fn_minmax: res = min_max_mid(a, b, c, ir.r2.sub);
			default:   res = dead_value;
			endcase
		op_addi:  res = a + imm;
		op_subfi: res = imm - a;
		op_andi:  res = a & imm;
		op_ori:   res = a | imm;
		op_eori:  res = a ^ imm;
		op_cmpi, op_cmpui:
			res = cmpo;
		op_muli:  res = prod_s[xlen-1:0];
		op_mului: res = prod_u[xlen-1:0];
		op_divi, op_divui:
			res = quo;
		op_shift: res = sh_res;
		op_chk:   res = '0;
		op_mov:   res = a;
		// Link value for a subroutine branch
		op_bsr:   res = pc + 4;
		op_nop:   res = '0;
		default:  res = dead_value;
		endcase
	end

	// ==============================
	// Checks and faults
	// ==============================
	always_comb
	begin
		// cond[1] opens the lower end, cond[0] closes the upper end
		lo_ok = ir.r2.cond[1] ? (a > b) : (a >= b);
		hi_ok = ir.r2.cond[0] ? (a <= c) : (a < c);
		in_rng = lo_ok && hi_ok;
		chk_fail = 1'b0;
		chk_unimp = 1'b0;
		case (ir.r2.cond)
		4'd0, 4'd1, 4'd2, 4'd3:
			chk_fail = !in_rng;
		4'd4, 4'd5, 4'd6, 4'd7:
			chk_fail = in_rng;
		4'd8:
			chk_fail = a < value_t'(cfg.cpl);
		4'd10:
			chk_fail = a != cfg.canary;
		default:
			chk_unimp = 1'b1;
		endcase

		exc = flt_none;
		if (ir.r2.opcode == op_chk)
		begin
			if (chk_unimp)
				exc = flt_unimp;
			else if (chk_fail)
				exc = ir.r2.cause;
		end
		else if (ir.r2.opcode == op_divi && div_dbz)
		begin
			exc = flt_dbz;
		end
	end

	// Predicated copy replaces the result with t or zero
	assign o = cptgt ? (z ? '0 : t) : res;

endmodule

`default_nettype wire

/* alu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_top
	import alu_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     ld,
	input  wire logic     cptgt,
	input  wire logic     z,
	input  wire logic     cfg_we,
	input  wire cfg_sel_t cfg_sel,
	input  wire value_t   cfg_wdata,
	input  wire instr_t   ir,
	input  wire value_t   a,
	input  wire value_t   b,
	input  wire value_t   c,
	input  wire value_t   t,
	input  wire value_t   imm,
	input  wire value_t   pc,
	output value_t        o,
	output logic          mul_done,
	output logic          div_done,
	output logic          div_dbz,
	output cause_t        exc
);

	cfg_t cfg;

	alu_cfg u_cfg (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_sel(cfg_sel),
		.cfg_wdata(cfg_wdata),
		.cfg(cfg)
	);

	alu_core u_core (
		.clk(clk), .rst(rst), .ld(ld), .cptgt(cptgt), .z(z),
		.ir(ir), .a(a), .b(b), .c(c), .t(t), .imm(imm), .pc(pc),
		.cfg(cfg),
		.o(o), .mul_done(mul_done), .div_done(div_done),
		.div_dbz(div_dbz), .exc(exc)
	);

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset is seen high by the first two rising edges
	initial
	begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* alu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_tb
	import alu_pkg::*;
;

	typedef struct packed {
		value_t a;
		value_t b;
		value_t c;
		value_t t;
		value_t imm;
		value_t pc;
	} operands_t;

	typedef struct packed {
		value_t o;
		cause_t exc;
	} expect_t;

	localparam int ops_total = 600 + 200 + 200 + 300 + 200;
	localparam int max_op_cycles = 40;
	localparam int timeout_cycles = ops_total * max_op_cycles * 3 / 2;

	logic      clk;
	logic      rst;
	logic      ld;
	logic      cptgt;
	logic      z;
	logic      cfg_we;
	cfg_sel_t  cfg_sel;
	value_t    cfg_wdata;
	instr_t    ir;
	operands_t ops;
	value_t    o;
	logic      mul_done;
	logic      div_done;
	logic      div_dbz;
	cause_t    exc;

	logic      check_on;
	logic      div_live;
	cfg_t      cfg_copy;
	logic [15:0] lfsr;
	int        cycles;
	int        idx;

	opcode_t comb_ops [14] = '{op_r2, op_r2, op_r2, op_addi, op_subfi, op_andi, op_ori,
		op_eori, op_cmpi, op_cmpui, op_shift, op_mov, op_bsr, op_nop};
	func_t comb_fns [19] = '{fn_add, fn_sub, fn_and, fn_or, fn_eor, fn_nand, fn_nor,
		fn_enor, fn_cmp, fn_cmpu, fn_seq, fn_sne, fn_slt, fn_sltu, fn_zseq, fn_zslt,
		fn_cmovz, fn_cmovnz, fn_minmax};

	tb_clkgen clkgen0 (.clk(clk), .rst(rst));

	alu_top dut0 (
		.clk(clk), .rst(rst), .ld(ld), .cptgt(cptgt), .z(z),
		.cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
		.ir(ir), .a(ops.a), .b(ops.b), .c(ops.c), .t(ops.t), .imm(ops.imm), .pc(ops.pc),
		.o(o), .mul_done(mul_done), .div_done(div_done), .div_dbz(div_dbz), .exc(exc)
	);

	// ==============================
	// Random source
	// ==============================
	// Taps for x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic value_t rand_bits(input int n);
		value_t v;
		logic   fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[xlen-2:0], fb};
		end
		return v;
	endfunction

	// ==============================
	// Reference model
	// ==============================
	function automatic logic is_less(value_t x, value_t y, logic sgn);
		return sgn ? ($signed(x) < $signed(y)) : (x < y);
	endfunction

	function automatic value_t mix_with_c(value_t x, value_t y, logic [3:0] sub);
		case (sub)
		4'd0: return x & y;
		4'd1: return x & ~y;
		4'd2: return x | y;
		4'd3: return x | ~y;
		4'd4: return x ^ y;
		4'd5: return x ^ ~y;
		default: return dead_value;
		endcase
	endfunction

	function automatic value_t cmp_flags(value_t x, value_t y, logic sgn);
		value_t f;
		f = '0;
		f[0] = (x == y);
		f[1] = is_less(x, y, sgn);
		f[2] = is_less(x, y, sgn) || (x == y);
		f[3] = is_less(y, x, sgn);
		f[4] = !is_less(x, y, sgn);
		return f;
	endfunction

	// Sorts the three values, then takes min, max or the middle one
	function automatic value_t pick_of_three(value_t x, value_t y, value_t w, logic [3:0] sub);
		value_t v [3];
		value_t tmp;
		logic   sgn;
		if (sub[3] || sub[1:0] == 2'd3)
			return dead_value;
		sgn = !sub[2];
		v[0] = x;
		v[1] = y;
		v[2] = w;
		for (int i = 0; i < 2; i++)
			for (int j = 0; j < 2 - i; j++)
				if (is_less(v[j+1], v[j], sgn))
				begin
					tmp = v[j];
					v[j] = v[j+1];
					v[j+1] = tmp;
				end
		case (sub[1:0])
		2'd0: return v[0];
		2'd1: return v[2];
		default: return v[1];
		endcase
	endfunction

	// Arithmetic shifts floor; the remainder below the result drives the rounding
	function automatic value_t shift_ref(instr_t w, value_t a, value_t b, value_t c);
		logic [5:0]         amt;
		logic [2*xlen-1:0]  fun;
		logic signed [63:0] a_ext;
		logic signed [63:0] q_ext;
		logic [63:0]        lost;
		value_t             q;
		amt = w.imm.amt_src ? w.imm.imm[5:0] : c[5:0];
		q = $signed(a) >>> amt;
		a_ext = {{32{a[xlen-1]}}, a};
		q_ext = {{32{q[xlen-1]}}, q};
		lost = a_ext - (q_ext << amt);
		case (w.imm.sht)
		sh_asl:
		begin
			fun = {a, b} << amt;
			return fun[2*xlen-1:xlen];
		end
		sh_lsr:
		begin
			fun = {b, a} >> amt;
			return fun[xlen-1:0];
		end
		sh_asr: return q;
		sh_asr_rz: return (q[xlen-1] && lost != 64'd0) ? q + 32'd1 : q;
		sh_asr_rh: return (amt == 6'd0) ? q : q + value_t'(lost[amt - 6'd1]);
		default: return dead_value;
		endcase
	endfunction

	// Truncating division on magnitudes; a zero divisor gives all ones and the dividend
	function automatic value_t divide_ref(value_t a, value_t d, logic sgn, logic want_rem);
		value_t ma;
		value_t md;
		value_t uq;
		value_t ur;
		if (d == '0)
			return want_rem ? a : '1;
		ma = (sgn && a[xlen-1]) ? -a : a;
		md = (sgn && d[xlen-1]) ? -d : d;
		uq = ma / md;
		ur = ma % md;
		if (want_rem)
			return (sgn && a[xlen-1]) ? -ur : ur;
		return (sgn && (a[xlen-1] ^ d[xlen-1])) ? -uq : uq;
	endfunction

	function automatic cause_t check_ref(instr_t w, operands_t x, cfg_t cf);
		logic lo;
		logic hi;
		logic inr;
		logic fail;
		lo = w.r2.cond[1] ? (x.a > x.b) : (x.a >= x.b);
		hi = w.r2.cond[0] ? (x.a <= x.c) : (x.a < x.c);
		inr = lo && hi;
		case (w.r2.cond)
		4'd0, 4'd1, 4'd2, 4'd3: fail = !inr;
		4'd4, 4'd5, 4'd6, 4'd7: fail = inr;
		4'd8: fail = x.a < {24'b0, cf.cpl};
		4'd10: fail = x.a != cf.canary;
		default: return flt_unimp;
		endcase
		return fail ? w.r2.cause : flt_none;
	endfunction

	function automatic expect_t expected_result(instr_t w, operands_t x, logic pred,
		logic zf, logic dv_live, cfg_t cf);
		expect_t e;
		value_t  bi;
		logic    sgn;
		bi = (w.r2.opcode inside {op_muli, op_mului, op_divi, op_divui}) ? x.imm : x.b;
		sgn = (w.r2.opcode == op_divi) ||
			(w.r2.opcode == op_r2 && (w.r2.func == fn_div || w.r2.func == fn_mod));
		e.exc = flt_none;
		if (w.r2.opcode == op_chk)
			e.exc = check_ref(w, x, cf);
		else if (w.r2.opcode == op_divi && dv_live && x.imm == '0)
			e.exc = flt_dbz;
		case (w.r2.opcode)
		op_r2:
			case (w.r2.func)
			fn_add:
				if (w.r2.sub == 4'd8)
					e.o = x.a + x.b + x.c;
				else if (w.r2.sub == 4'd9)
					e.o = x.a + x.b - x.c;
				else
					e.o = mix_with_c(x.a + x.b, x.c, w.r2.sub);
			fn_sub: e.o = x.a - x.b - x.c;
			fn_and: e.o = mix_with_c(x.a & x.b, x.c, w.r2.sub);
			fn_or: e.o = mix_with_c(x.a | x.b, x.c, w.r2.sub);
			fn_eor: e.o = mix_with_c(x.a ^ x.b, x.c, w.r2.sub);
			fn_nand: e.o = mix_with_c(~(x.a & x.b), x.c, w.r2.sub);
			fn_nor: e.o = mix_with_c(~(x.a | x.b), x.c, w.r2.sub);
			fn_enor: e.o = mix_with_c(~(x.a ^ x.b), x.c, w.r2.sub);
			fn_cmp, fn_cmpu:
			begin
				e.o = cmp_flags(x.a, x.b, w.r2.func == fn_cmp);
				if (w.r2.sub < 4'd6)
					e.o = mix_with_c(e.o, x.c, w.r2.sub);
			end
			fn_mul, fn_mulu: e.o = x.a * bi;
			fn_div, fn_divu: e.o = divide_ref(x.a, bi, sgn, 1'b0);
			fn_mod, fn_modu: e.o = divide_ref(x.a, bi, sgn, 1'b1);
			fn_seq: e.o = (x.a == x.b) ? x.c : x.t;
			fn_sne: e.o = (x.a != x.b) ? x.c : x.t;
			fn_slt: e.o = is_less(x.a, x.b, 1'b1) ? x.c : x.t;
			fn_sltu: e.o = is_less(x.a, x.b, 1'b0) ? x.c : x.t;
			fn_zseq: e.o = (x.a == x.b) ? x.c : '0;
			fn_zslt: e.o = is_less(x.a, x.b, 1'b1) ? x.c : '0;
			fn_cmovz: e.o = (x.a == '0) ? x.b : x.c;
			fn_cmovnz: e.o = (x.a != '0) ? x.b : x.c;
			fn_minmax: e.o = pick_of_three(x.a, x.b, x.c, w.r2.sub);
			default: e.o = dead_value;
			endcase
		op_addi: e.o = x.a + x.imm;
		op_subfi: e.o = x.imm - x.a;
		op_andi: e.o = x.a & x.imm;
		op_ori: e.o = x.a | x.imm;
		op_eori: e.o = x.a ^ x.imm;
		op_cmpi: e.o = cmp_flags(x.a, x.imm, 1'b1);
		op_cmpui: e.o = cmp_flags(x.a, x.imm, 1'b0);
		op_muli, op_mului: e.o = x.a * bi;
		op_divi, op_divui: e.o = divide_ref(x.a, bi, sgn, 1'b0);
		op_shift: e.o = shift_ref(w, x.a, x.b, x.c);
		op_mov: e.o = x.a;
		op_bsr: e.o = x.pc + 32'd4;
		op_chk, op_nop: e.o = '0;
		default: e.o = dead_value;
		endcase
		if (pred)
			e.o = zf ? '0 : x.t;
		return e;
	endfunction

	// ==============================
	// Checking
	// ==============================
	task automatic check_value(input value_t got, input value_t want, input string what);
		if (got !== want)
		begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
			$display("Test failures found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Samples one nanosecond before each rising edge
	always
	begin
		expect_t e;
		value_t  divisor;
		@(negedge clk);
		#4;
		if (check_on)
		begin
			e = expected_result(ir, ops, cptgt, z, div_live, cfg_copy);
			check_value(o, e.o, "result o");
			check_value(value_t'(exc), value_t'(e.exc), "cause exc");
			if (div_live)
			begin
				divisor = (ir.r2.opcode inside {op_divi, op_divui}) ? ops.imm : ops.b;
				check_value(value_t'(div_dbz), value_t'(divisor == '0), "div_dbz");
			end
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > timeout_cycles)
		begin
			$display("Test failures found");
			$fatal(1, "Timeout: the run went past %0d cycles", timeout_cycles);
		end
	end

	task automatic randomize_ops();
		ops.a = rand_bits(32);
		ops.b = rand_bits(32);
		ops.c = rand_bits(32);
		ops.t = rand_bits(32);
		ops.imm = rand_bits(32);
		ops.pc = rand_bits(32);
		ir = instr_t'(rand_bits(32));
	endtask

	// ==============================
	// Stimulus
	// ==============================
	initial
	begin
		lfsr = 16'd25864;
		cycles = 0;
		ld = 1'b0;
		cptgt = 1'b0;
		z = 1'b0;
		cfg_we = 1'b0;
		cfg_sel = cfg_canary;
		cfg_wdata = '0;
		ir = '0;
		ops = '0;
		check_on = 1'b0;
		div_live = 1'b0;
		cfg_copy = '0;

		@(negedge clk);
		while (rst)
			@(negedge clk);
		check_value(value_t'(mul_done), '0, "mul_done after reset");
		check_value(value_t'(div_done), '0, "div_done after reset");
		check_value(value_t'(div_dbz), '0, "div_dbz after reset");

		// Single-cycle operations
		for (int n = 0; n < 600; n++)
		begin
			randomize_ops();
			idx = int'(rand_bits(8) % 32'd14);
			ir.r2.opcode = comb_ops[idx];
			idx = int'(rand_bits(8) % 32'd19);
			ir.r2.func = comb_fns[idx];
			if (rand_bits(2) == '0)
				ops.b = ops.a;
			if (rand_bits(3) == '0)
				ops.a = '0;
			check_on = 1'b1;
			@(negedge clk);
		end
		check_on = 1'b0;

		// Checks against a fresh canary and cpl in each round
		for (int r = 0; r < 3; r++)
		begin
			cfg_we = 1'b1;
			cfg_sel = cfg_canary;
			cfg_wdata = rand_bits(32);
			@(negedge clk);
			cfg_copy.canary = cfg_wdata;
			cfg_sel = cfg_cpl;
			cfg_wdata = rand_bits(32);
			@(negedge clk);
			cfg_copy.cpl = cfg_wdata[7:0];
			cfg_we = 1'b0;
			for (int n = 0; n < 100; n++)
			begin
				randomize_ops();
				ir.r2.opcode = op_chk;
				if (ir.r2.cond == 4'd10 && rand_bits(1) == '0)
					ops.a = cfg_copy.canary;
				if (ir.r2.cond == 4'd8 && rand_bits(1) == '0)
					ops.a = rand_bits(8);
				check_on = 1'b1;
				@(negedge clk);
			end
			check_on = 1'b0;
		end

		// Predicated copy under any opcode
		for (int n = 0; n < 200; n++)
		begin
			randomize_ops();
			cptgt = 1'b1;
			z = rand_bits(1) != '0;
			check_on = 1'b1;
			@(negedge clk);
		end
		check_on = 1'b0;
		cptgt = 1'b0;

		for (int n = 0; n < 200; n++)
		begin
			randomize_ops();
			case (rand_bits(2))
			32'd0: {ir.r2.opcode, ir.r2.func} = {op_r2, fn_mul};
			32'd1: {ir.r2.opcode, ir.r2.func} = {op_r2, fn_mulu};
			32'd2: ir.r2.opcode = op_muli;
			default: ir.r2.opcode = op_mului;
			endcase
			check_on = 1'b0;
			ld = 1'b1;
			@(negedge clk);
			ld = 1'b0;
			while (!mul_done)
				@(negedge clk);
			check_on = 1'b1;
			@(negedge clk);
		end
		check_on = 1'b0;

		div_live = 1'b1;
		for (int n = 0; n < 200; n++)
		begin
			randomize_ops();
			case (rand_bits(3) % 32'd6)
			32'd0: {ir.r2.opcode, ir.r2.func} = {op_r2, fn_div};
			32'd1: {ir.r2.opcode, ir.r2.func} = {op_r2, fn_divu};
			32'd2: {ir.r2.opcode, ir.r2.func} = {op_r2, fn_mod};
			32'd3: {ir.r2.opcode, ir.r2.func} = {op_r2, fn_modu};
			32'd4: ir.r2.opcode = op_divi;
			default: ir.r2.opcode = op_divui;
			endcase
			if (rand_bits(2) == '0)
			begin
				ops.b = '0;
				ops.imm = '0;
			end
			else if (rand_bits(3) == '0)
			begin
				ops.a = 32'h8000_0000;
				ops.b = '1;
				ops.imm = '1;
			end
			check_on = 1'b0;
			ld = 1'b1;
			@(negedge clk);
			ld = 1'b0;
			while (!div_done)
				@(negedge clk);
			check_on = 1'b1;
			@(negedge clk);
		end
		check_on = 1'b0;
		@(negedge clk);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
alu_pkg.sv
alu_cfg.sv
alu_cmp.sv
alu_shift.sv
alu_mul.sv
alu_div.sv
alu_core.sv
alu_top.sv
tb_clkgen.sv
alu_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status carries pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing -f files.f --top-module alu_tb -o alu_sim &&
./obj_dir/alu_sim || exit 1
